//--- Makefile
TOP     := uart_link_tb
SOURCES := $(shell grep -v '^+' verilog.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): verilog.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f verilog.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- common/uart_pkg.sv
package uart_pkg;

    // byte and oversampling
    localparam int DATA_BITS    = 8;
    localparam int OVERSAMPLE   = 8;

    // both sides run at the same bit rate off clk
    localparam int RX_DIVIDE    = 5;
    localparam int TX_DIVIDE    = RX_DIVIDE * OVERSAMPLE;

    // start + data + parity + stop
    localparam int FRAME_BITS   = DATA_BITS + 3;
    localparam int SAMPLE_POINT = OVERSAMPLE / 2;   // mid-bit

    typedef logic [DATA_BITS-1:0]  byte_t;
    typedef logic [FRAME_BITS-1:0] frame_t;    // bit 0 is start, then data lsb first
    typedef logic [3:0]            bit_count_t;
    typedef logic [2:0]            sample_count_t;

    typedef enum logic [2:0]
    {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP,
        ERROR
    } rx_state_t;

    // data plus parity bit hold an odd number of ones
    function automatic logic odd_parity(input byte_t data);
        return ~(^data);
    endfunction

endpackage

//--- design/baud_tick_gen.sv
module baud_tick_gen
    import uart_pkg::*;
#(
    parameter int DIVIDE = TX_DIVIDE
)
(
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int CW = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

    logic [CW-1:0] count;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count == CW'(DIVIDE - 1))
        begin
            count <= '0;
            tick  <= 1'b1;   // one cycle out of DIVIDE
        end
        else
        begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

//--- design/uart_link.sv
module uart_link
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  send,
    input  byte_t data_in,
    input  logic  rx_line,
    output logic  tx_line,
    output logic  busy,
    output byte_t rx_data,
    output logic  rx_valid,
    output logic  rx_error
);

    logic tx_tick;
    logic rx_tick;
    logic resend;   // receiver asks for the held frame again

    baud_tick_gen #(.DIVIDE(TX_DIVIDE)) tx_baud
    (
        .clk   (clk),
        .reset (reset),
        .tick  (tx_tick)
    );

    baud_tick_gen #(.DIVIDE(RX_DIVIDE)) rx_baud
    (
        .clk   (clk),
        .reset (reset),
        .tick  (rx_tick)
    );

    uart_tx uart_tx_i
    (
        .clk     (clk),
        .reset   (reset),
        .tick    (tx_tick),
        .send    (send),
        .data_in (data_in),
        .resend  (resend),
        .tx_line (tx_line),
        .busy    (busy)
    );

    uart_rx uart_rx_i
    (
        .clk      (clk),
        .reset    (reset),
        .tick     (rx_tick),
        .rx_line  (rx_line),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_error (rx_error),
        .resend   (resend)
    );

endmodule

//--- receiver/uart_rx.sv
module uart_rx
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  tick,
    input  logic  rx_line,
    output byte_t rx_data,
    output logic  rx_valid,
    output logic  rx_error,
    output logic  resend
);

    rx_state_t     state;
    sample_count_t sample_count;   // tick index within the current bit
    bit_count_t    bit_count;
    byte_t         data_shift;
    logic          sample_now;
    logic          bit_end;

    assign sample_now = tick && (sample_count == sample_count_t'(SAMPLE_POINT));
    assign bit_end    = tick && (sample_count == sample_count_t'(OVERSAMPLE - 1));

    // a bad frame and the resend request are one event
    assign resend = rx_error;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= IDLE;
            sample_count <= '0;
            bit_count    <= '0;
            data_shift   <= '0;
            rx_data      <= '0;
            rx_valid     <= 1'b0;
            rx_error     <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            rx_error <= 1'b0;

            if (tick)
            begin
                sample_count <= sample_count + 1'b1;   // wraps once per bit
            end

            case (state)
                IDLE:
                begin
                    if (tick && !rx_line)
                    begin
                        state        <= START;
                        sample_count <= sample_count_t'(1);   // this tick was index 0
                    end
                end

                START:
                begin
                    if (sample_now && rx_line)
                    begin
                        state <= IDLE;   // a glitch rather than a start bit
                    end
                    else if (bit_end)
                    begin
                        state     <= DATA;
                        bit_count <= '0;
                    end
                end

                DATA:
                begin
                    if (sample_now)
                    begin
                        data_shift <= {rx_line, data_shift[DATA_BITS-1:1]};   // lsb first
                        bit_count  <= bit_count + 1'b1;
                    end
                    if (bit_end && bit_count == bit_count_t'(DATA_BITS))
                    begin
                        state <= PARITY;
                    end
                end

                PARITY:
                begin
                    if (sample_now && rx_line != odd_parity(data_shift))
                    begin
                        state    <= ERROR;
                        rx_error <= 1'b1;
                    end
                    else if (bit_end)
                    begin
                        state <= STOP;
                    end
                end

                STOP:
                begin
                    if (sample_now)
                    begin
                        if (rx_line)
                        begin
                            rx_data  <= data_shift;
                            rx_valid <= 1'b1;
                            state    <= IDLE;   // back early to catch the next start edge
                        end
                        else
                        begin
                            state    <= ERROR;   // framing error
                            rx_error <= 1'b1;
                        end
                    end
                end

                ERROR:
                begin
                    // stay until a bit ends on an idle line
                    if (bit_end && rx_line)
                    begin
                        state <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    valid_error_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(rx_valid && rx_error))
        else $error("rx_valid and rx_error high in the same cycle");

endmodule

//--- tests/tb_clock.sv
module tb_clock
(
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

//--- tests/uart_checker.sv
module uart_checker
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  send,
    input  byte_t data_in,
    input  logic  busy,
    input  logic  tx_line,
    input  logic  rx_line,
    input  byte_t rx_data,
    input  logic  rx_valid,
    input  logic  rx_error,
    input  logic  run_done,
    output logic  checks_done,
    output int    data_errors,
    output int    line_errors,
    output int    pulse_errors,
    output int    end_errors
);

    timeunit 1ns;
    timeprecision 100ps;

    byte_t expected[$];            // accepted bytes still in flight
    byte_t want;
    logic  frame_corrupted = 1'b0;
    logic  finished = 1'b0;
    int    corrupted_frames = 0;
    int    error_pulses = 0;       // rx_error pulses that matched a corrupted frame
    int    data_count = 0;
    int    line_count = 0;
    int    pulse_count = 0;
    int    end_count = 0;

    assign checks_done  = finished;
    assign data_errors  = data_count;
    assign line_errors  = line_count;
    assign pulse_errors = pulse_count;
    assign end_errors   = end_count;

    always @(posedge clk)
    begin
        if (reset)
        begin
            if (rx_valid || rx_error || busy || !tx_line)
            begin
                $display("ERROR reset values rx_valid 0x%0h rx_error 0x%0h busy 0x%0h tx_line 0x%0h",
                         rx_valid, rx_error, busy, tx_line);
                line_count++;
            end
        end
        else
        begin
            if (send && !busy)
                expected.push_back(data_in);

            if (!busy && !tx_line)
            begin
                $display("ERROR tx_line expected 0x1 got 0x%0h while busy is low", tx_line);
                line_count++;
            end

            // one mismatch anywhere in a frame marks the whole frame
            if (rx_line != tx_line && !frame_corrupted)
            begin
                frame_corrupted = 1'b1;
                corrupted_frames++;
            end

            if (rx_valid)
            begin
                if (frame_corrupted)
                begin
                    $display("rx_valid came for a frame that was corrupted on the line");
                    pulse_count++;
                    frame_corrupted = 1'b0;
                end
                if (expected.size() == 0)
                begin
                    $display("rx_valid came with no accepted byte outstanding");
                    data_count++;
                end
                else
                begin
                    want = expected.pop_front();
                    if (rx_data !== want)
                    begin
                        $display("ERROR rx_data expected 0x%02h got 0x%02h", want, rx_data);
                        data_count++;
                    end
                end
            end

            if (rx_error)
            begin
                if (frame_corrupted)
                begin
                    error_pulses++;
                    frame_corrupted = 1'b0;   // resend follows with the same byte
                end
                else
                begin
                    $display("rx_error pulsed without a corrupted frame");
                    pulse_count++;
                end
            end

            if (run_done && !finished)
            begin
                if (expected.size() != 0)
                begin
                    $display("%0d accepted bytes were never received", expected.size());
                    end_count++;
                end
                if (error_pulses != corrupted_frames)
                begin
                    $display("%0d rx_error pulses for %0d corrupted frames",
                             error_pulses, corrupted_frames);
                    end_count++;
                end
                finished <= 1'b1;
            end
        end
    end

endmodule

//--- tests/uart_link_tb.sv
module uart_link_tb
    import uart_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_BYTES      = 40;
    localparam int MAX_GAP        = 200;
    localparam int TIMEOUT_CYCLES = NUM_BYTES * 1000 + 2000;
    localparam int DRIVE_DELAY    = 2;

    logic        clk;
    logic        reset;
    logic        send;
    byte_t       data_in;
    logic        rx_line = 1'b1;
    logic        corrupt;
    logic        tx_line;
    logic        busy;
    byte_t       rx_data;
    logic        rx_valid;
    logic        rx_error;
    logic        run_done;
    logic        checks_done;
    int          data_errors;
    int          line_errors;
    int          pulse_errors;
    int          end_errors;
    logic [31:0] seed = 32'd14560;
    int          cycles = 0;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic print_counts;
        $display("errors: %0d data, %0d line, %0d rx_error, %0d end of run",
                 data_errors, line_errors, pulse_errors, end_errors);
    endtask

    // idle cycles; send is raised with junk only where busy makes it void
    task automatic idle_gap(input int length);
        repeat (length)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            send    = busy;
            data_in = ~data_in;
        end
    endtask

    task automatic send_byte(input byte_t value);
        send    = 1'b1;
        data_in = value;
        do
            @(posedge clk);
        while (busy);   // taken on the edge that saw busy low
        #DRIVE_DELAY;
        send = 1'b0;
    endtask

    // flips one data bit for its whole bit time on the first transmission
    task automatic corrupt_data_bit(input int bit_index);
        do
            @(posedge clk);
        while (tx_line);   // start bit began one edge earlier
        repeat (TX_DIVIDE * (bit_index + 1) - 1) @(posedge clk);
        corrupt = 1'b1;
        repeat (TX_DIVIDE) @(posedge clk);
        corrupt = 1'b0;
        #DRIVE_DELAY;
    endtask

    always @(posedge clk)
    begin
        #DRIVE_DELAY;
        rx_line = tx_line ^ corrupt;
    end

    initial
    begin
        byte_t value;
        int    gap;
        logic  do_corrupt;
        int    bit_index;

        send     = 1'b0;
        data_in  = '0;
        corrupt  = 1'b0;
        run_done = 1'b0;
        wait (!reset);
        @(posedge clk);
        #DRIVE_DELAY;
        for (int i = 0; i < NUM_BYTES; i++)
        begin
            seed       = lcg_step(seed);
            value      = seed[23:16];
            gap        = int'({17'd0, seed[30:16]} % 32'(MAX_GAP + 1));
            seed       = lcg_step(seed);
            do_corrupt = (seed[31:16] % 16'd5) == 16'd0;   // about one frame in five
            bit_index  = int'(seed[18:16]);
            idle_gap(gap);
            send_byte(value);
            if (do_corrupt)
                corrupt_data_bit(bit_index);
        end
        do
            @(posedge clk);
        while (busy);   // last rx_valid comes before busy falls
        #DRIVE_DELAY;
        run_done = 1'b1;
        do
            @(posedge clk);
        while (!checks_done);
        print_counts();
        if (data_errors + line_errors + pulse_errors + end_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("test failed");
            $finish;
        end
    end

    tb_clock clock_gen
    (
        .clk   (clk),
        .reset (reset)
    );

    uart_link uart_link_i
    (
        .clk      (clk),
        .reset    (reset),
        .send     (send),
        .data_in  (data_in),
        .rx_line  (rx_line),
        .tx_line  (tx_line),
        .busy     (busy),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_error (rx_error)
    );

    uart_checker link_checker
    (
        .clk          (clk),
        .reset        (reset),
        .send         (send),
        .data_in      (data_in),
        .busy         (busy),
        .tx_line      (tx_line),
        .rx_line      (rx_line),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_error     (rx_error),
        .run_done     (run_done),
        .checks_done  (checks_done),
        .data_errors  (data_errors),
        .line_errors  (line_errors),
        .pulse_errors (pulse_errors),
        .end_errors   (end_errors)
    );

endmodule

//--- transmitter/uart_tx.sv
module uart_tx
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  tick,
    input  logic  send,
    input  byte_t data_in,
    input  logic  resend,
    output logic  tx_line,
    output logic  busy
);

    frame_t     new_frame;
    frame_t     shift_reg;
    frame_t     hold_frame;       // copy kept for a resend
    bit_count_t bit_count;
    logic       resend_pending;
    logic       frame_done;

    assign new_frame  = {1'b1, odd_parity(data_in), data_in, 1'b0};

    // stop bit has been on the line for a full bit time
    assign frame_done = tick && (bit_count == bit_count_t'(FRAME_BITS));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tx_line        <= 1'b1;
            busy           <= 1'b0;
            shift_reg      <= '1;
            hold_frame     <= '1;
            bit_count      <= '0;
            resend_pending <= 1'b0;
        end
        else
        begin
            if (resend && busy)
            begin
                resend_pending <= 1'b1;   // served when this frame ends
            end

            if (!busy)
            begin
                if (send)
                begin
                    shift_reg  <= new_frame;
                    hold_frame <= new_frame;
                    bit_count  <= '0;
                    busy       <= 1'b1;
                end
            end
            else if (frame_done)
            begin
                bit_count <= '0;
                if (resend_pending || resend)
                begin
                    shift_reg      <= hold_frame;   // starts at the next tick
                    resend_pending <= 1'b0;
                end
                else
                begin
                    busy <= 1'b0;
                end
            end
            else if (tick)
            begin
                tx_line   <= shift_reg[0];
                shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};   // ones keep the line idle
                bit_count <= bit_count + 1'b1;
            end
        end
    end

    // the line only leaves idle while a frame is in flight
    idle_line_high: assert property (@(posedge clk) disable iff (reset) !busy |-> tx_line)
        else $error("tx_line low while transmitter is idle");

endmodule

//--- verilog.f
common/uart_pkg.sv
design/baud_tick_gen.sv
transmitter/uart_tx.sv
receiver/uart_rx.sv
design/uart_link.sv
tests/tb_clock.sv
tests/uart_checker.sv
tests/uart_link_tb.sv
